// File: source/mbox_pkg.sv
package mbox_pkg;

    // FIFO geometry
    localparam int data_width = 32;
    localparam int fifo_depth = 8;
    localparam int addr_width = 3;    // Pointer width, log2 of depth

    // Flag thresholds on the occupancy count
    localparam int afull_level  = 7;
    localparam int aempty_level = 1;

    // AXI4-Lite byte address width
    localparam int axil_addr_width = 4;

    // Register map, byte offsets
    localparam logic [axil_addr_width-1:0] reg_data   = 4'h0; // Write pushes, read pops
    localparam logic [axil_addr_width-1:0] reg_status = 4'h4; // Flags, sticky bits W1C
    localparam logic [axil_addr_width-1:0] reg_count  = 4'h8; // Read only

    // Status word bit positions
    localparam int st_empty     = 0;
    localparam int st_full      = 1;
    localparam int st_aempty    = 2;
    localparam int st_afull     = 3;
    localparam int st_overflow  = 4;  // Sticky
    localparam int st_underflow = 5;  // Sticky

    // Response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            push,
    input  logic [mbox_pkg::data_width-1:0] push_data,
    input  logic                            pop,
    output logic [mbox_pkg::data_width-1:0] pop_data,
    output logic [mbox_pkg::addr_width:0]   count,
    output logic                            full,
    output logic                            empty,
    output logic                            almost_full,
    output logic                            almost_empty,
    output logic                            overflow,
    output logic                            underflow
);

    logic [mbox_pkg::addr_width-1:0] wr_ptr;
    logic [mbox_pkg::addr_width-1:0] rd_ptr;
    logic [mbox_pkg::data_width-1:0] mem [mbox_pkg::fifo_depth];

    logic push_ok;
    logic pop_ok;

    // Rejected operations are dropped entirely
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // Write pointer, wraps only when it advances
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push_ok) begin
            if (wr_ptr == mbox_pkg::fifo_depth - 1)
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop_ok) begin
            if (rd_ptr == mbox_pkg::fifo_depth - 1)
                rd_ptr <= '0;
            else
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= push_data;
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (pop_ok)
            pop_data <= mem[rd_ptr];
        else if (pop)
            pop_data <= '0;                  // Pop on empty reads zero
    end

    assign full         = (count == mbox_pkg::fifo_depth);
    assign empty        = (count == 0);
    assign almost_full  = (count >= mbox_pkg::afull_level);
    assign almost_empty = (count <= mbox_pkg::aempty_level);

    // One-cycle error pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow  <= push && full;
            underflow <= pop && empty;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= mbox_pkg::fifo_depth
    ) else $error("FIFO count above depth");

    a_full_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(full && empty)
    ) else $error("FIFO full and empty together");

    // Pointer distance must agree with the count
    a_ptr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_ptr < mbox_pkg::fifo_depth) && (rd_ptr < mbox_pkg::fifo_depth) &&
        (((wr_ptr - rd_ptr) & (mbox_pkg::fifo_depth - 1)) ==
         (count & (mbox_pkg::fifo_depth - 1)))
    ) else $error("FIFO pointers out of range or out of step with count");

endmodule

// File: source/mbox_axil_regs.sv
`timescale 1ns/1ps

module mbox_axil_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [mbox_pkg::axil_addr_width-1:0] awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [mbox_pkg::data_width-1:0]      wdata,
    input  logic                                 wvalid,
    output logic                                 wready,
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    input  logic [mbox_pkg::axil_addr_width-1:0] araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [mbox_pkg::data_width-1:0]      rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  logic                                 rready,
    output logic                                 push,
    output logic [mbox_pkg::data_width-1:0]      push_data,
    output logic                                 pop,
    input  logic [mbox_pkg::data_width-1:0]      pop_data,
    input  logic [mbox_pkg::addr_width:0]        count,
    input  logic                                 full,
    input  logic                                 empty,
    input  logic                                 almost_full,
    input  logic                                 almost_empty,
    input  logic                                 overflow,
    input  logic                                 underflow
);

    logic wr_fire;
    logic wr_is_data;
    logic wr_is_status;
    logic rd_fire;
    logic rd_is_data;
    logic rd_is_status;
    logic rd_is_count;
    logic sticky_ovf;
    logic sticky_unf;
    logic rd_s1;                 // Read accepted last cycle
    logic rd_data_s1;
    logic rd_err_s1;
    logic [mbox_pkg::data_width-1:0] rd_word_s1;
    logic [mbox_pkg::data_width-1:0] status_word;

    // Address and data taken together, one response outstanding
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign wr_is_data   = (awaddr == mbox_pkg::reg_data);
    assign wr_is_status = (awaddr == mbox_pkg::reg_status);

    assign push      = wr_fire && wr_is_data;
    assign push_data = wdata;

    // Next read waits until the previous one has answered
    assign rd_fire = arvalid && !rd_s1 && !rvalid;
    assign arready = rd_fire;

    assign rd_is_data   = (araddr == mbox_pkg::reg_data);
    assign rd_is_status = (araddr == mbox_pkg::reg_status);
    assign rd_is_count  = (araddr == mbox_pkg::reg_count);

    assign pop = rd_fire && rd_is_data;

    always_comb begin
        status_word = '0;
        status_word[mbox_pkg::st_empty]     = empty;
        status_word[mbox_pkg::st_full]      = full;
        status_word[mbox_pkg::st_aempty]    = almost_empty;
        status_word[mbox_pkg::st_afull]     = almost_full;
        status_word[mbox_pkg::st_overflow]  = sticky_ovf;
        status_word[mbox_pkg::st_underflow] = sticky_unf;
    end

    // Sticky errors, a new pulse beats a clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sticky_ovf <= 1'b0;
            sticky_unf <= 1'b0;
        end else begin
            if (overflow)
                sticky_ovf <= 1'b1;
            else if (wr_fire && wr_is_status && wdata[mbox_pkg::st_overflow])
                sticky_ovf <= 1'b0;
            if (underflow)
                sticky_unf <= 1'b1;
            else if (wr_fire && wr_is_status && wdata[mbox_pkg::st_underflow])
                sticky_unf <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rd_s1  <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            rd_s1 <= rd_fire;
            if (rd_s1)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Response payloads
    always_ff @(posedge clk) begin
        if (wr_fire)
            bresp <= (wr_is_data || wr_is_status) ? mbox_pkg::resp_okay
                                                  : mbox_pkg::resp_slverr;
        if (rd_fire) begin
            rd_data_s1 <= rd_is_data;
            rd_err_s1  <= !(rd_is_data || rd_is_status || rd_is_count);
            if (rd_is_status)
                rd_word_s1 <= status_word;
            else if (rd_is_count)
                rd_word_s1 <= mbox_pkg::data_width'(count);
            else
                rd_word_s1 <= '0;
        end
        if (rd_s1) begin
            rdata <= rd_data_s1 ? pop_data : rd_word_s1;   // pop_data settled by now
            rresp <= rd_err_s1 ? mbox_pkg::resp_slverr : mbox_pkg::resp_okay;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    ) else $error("bvalid dropped before handshake");

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else $error("rvalid dropped before handshake");

    // A push must belong to a write that answers okay next cycle
    a_push_accepted: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (awvalid && awready && wvalid && wready) ##1
                 (bvalid && bresp == mbox_pkg::resp_okay)
    ) else $error("push outside an accepted write");

    // A pop must belong to a read that answers two cycles later
    a_pop_accepted: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> (arvalid && arready) ##2 rvalid
    ) else $error("pop outside an accepted read");

endmodule

// File: source/mbox_top.sv
`timescale 1ns/1ps

module mbox_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [mbox_pkg::axil_addr_width-1:0] awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [mbox_pkg::data_width-1:0]      wdata,
    input  logic                                 wvalid,
    output logic                                 wready,
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    input  logic [mbox_pkg::axil_addr_width-1:0] araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [mbox_pkg::data_width-1:0]      rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  logic                                 rready
);

    logic                            push;
    logic [mbox_pkg::data_width-1:0] push_data;
    logic                            pop;
    logic [mbox_pkg::data_width-1:0] pop_data;
    logic [mbox_pkg::addr_width:0]   count;
    logic                            full;
    logic                            empty;
    logic                            almost_full;
    logic                            almost_empty;
    logic                            overflow;
    logic                            underflow;

    mbox_axil_regs i_regs (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .push, .push_data, .pop, .pop_data, .count,
        .full, .empty, .almost_full, .almost_empty, .overflow, .underflow
    );

    sync_fifo i_fifo (
        .clk, .rst_n,
        .push, .push_data, .pop, .pop_data, .count,
        .full, .empty, .almost_full, .almost_empty, .overflow, .underflow
    );

endmodule

// File: tests/mbox_checker.sv
`timescale 1ns/1ps

module mbox_checker (
    input logic                            clk,
    input logic                            rst_n,
    input logic [1:0]                      bresp,
    input logic                            bvalid,
    input logic                            bready,
    input logic [mbox_pkg::data_width-1:0] rdata,
    input logic [1:0]                      rresp,
    input logic                            rvalid,
    input logic                            rready
);

    string                           b_name [$];
    logic [1:0]                      b_resp [$];
    string                           r_name [$];
    logic [1:0]                      r_resp [$];
    logic [mbox_pkg::data_width-1:0] r_data [$];

    int pass_count = 0;
    int fail_count = 0;

    string                           name_now;
    logic [1:0]                      resp_now;
    logic [mbox_pkg::data_width-1:0] data_now;

    task automatic expect_write(input string name, input logic [1:0] resp);
        b_name.push_back(name);
        b_resp.push_back(resp);
    endtask

    task automatic expect_read(input string name, input logic [1:0] resp,
                               input logic [mbox_pkg::data_width-1:0] data);
        r_name.push_back(name);
        r_resp.push_back(resp);
        r_data.push_back(data);
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        fail_count++;
    endtask

    task automatic check_drained();
        if (b_name.size() != 0 || r_name.size() != 0)
            note_failure("Some expected responses never arrived");
    endtask

    task automatic report_counts();
        $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
    endtask

    always @(posedge clk) begin
        if (rst_n && bvalid && bready) begin
            if (b_name.size() == 0) begin
                note_failure("A write response arrived with no write outstanding");
            end else begin
                name_now = b_name.pop_front();
                resp_now = b_resp.pop_front();
                if (bresp === resp_now) begin
                    $display("Pass %s", name_now);
                    pass_count++;
                end else begin
                    $display("Mismatch %s expected bresp %0d actual bresp %0d",
                             name_now, resp_now, bresp);
                    fail_count++;
                end
            end
        end
        if (rst_n && rvalid && rready) begin
            if (r_name.size() == 0) begin
                note_failure("A read response arrived with no read outstanding");
            end else begin
                name_now = r_name.pop_front();
                resp_now = r_resp.pop_front();
                data_now = r_data.pop_front();
                if (rresp === resp_now && rdata === data_now) begin
                    $display("Pass %s", name_now);
                    pass_count++;
                end else begin
                    $display("Mismatch %s expected %0d/%h actual %0d/%h",
                             name_now, resp_now, data_now, rresp, rdata);   // resp/data
                    fail_count++;
                end
            end
        end
    end

endmodule

// File: tests/tb_mbox.sv
`timescale 1ns/1ps

module tb_mbox;

    localparam int          wait_limit = 64;     // Cycles per handshake
    localparam int          random_ops = 200;
    localparam logic [31:0] seed       = 32'h22a0_8a84;

    logic                                 clk;
    logic                                 rst_n;
    logic [mbox_pkg::axil_addr_width-1:0] awaddr;
    logic                                 awvalid;
    logic                                 awready;
    logic [mbox_pkg::data_width-1:0]      wdata;
    logic                                 wvalid;
    logic                                 wready;
    logic [1:0]                           bresp;
    logic                                 bvalid;
    logic                                 bready;
    logic [mbox_pkg::axil_addr_width-1:0] araddr;
    logic                                 arvalid;
    logic                                 arready;
    logic [mbox_pkg::data_width-1:0]      rdata;
    logic [1:0]                           rresp;
    logic                                 rvalid;
    logic                                 rready;

    logic                            stall_en;
    logic [31:0]                     rand_state;
    logic [31:0]                     stall_state;
    logic [mbox_pkg::data_width-1:0] model [$];   // Expected FIFO contents

    mbox_top i_dut (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    mbox_checker i_check (
        .clk, .rst_n,
        .bresp, .bvalid, .bready,
        .rdata, .rresp, .rvalid, .rready
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Status word expected for a given occupancy
    function automatic logic [31:0] status_for(input int n, input logic ovf, input logic unf);
        logic [31:0] s;
        s = '0;
        s[mbox_pkg::st_empty]     = (n == 0);
        s[mbox_pkg::st_full]      = (n == mbox_pkg::fifo_depth);
        s[mbox_pkg::st_aempty]    = (n <= mbox_pkg::aempty_level);
        s[mbox_pkg::st_afull]     = (n >= mbox_pkg::afull_level);
        s[mbox_pkg::st_overflow]  = ovf;
        s[mbox_pkg::st_underflow] = unf;
        return s;
    endfunction

    function automatic logic handshake_seen(input int which);
        case (which)
            0:       return awvalid && awready && wvalid && wready;
            1:       return bvalid && bready;
            2:       return arvalid && arready;
            default: return rvalid && rready;
        endcase
    endfunction

    task automatic stop_on_timeout(input string what);
        i_check.note_failure({"Timeout waiting for the ", what, " handshake"});
        i_check.report_counts();
        $display("Some tests failed");
        $finish;
    endtask

    task automatic wait_handshake(input int which, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!handshake_seen(which)) begin
            n++;
            if (n >= wait_limit)
                stop_on_timeout(what);
            @(posedge clk);
        end
    endtask

    task automatic axil_write(input string name, input logic [3:0] addr,
                              input logic [31:0] data, input logic [1:0] resp);
        i_check.expect_write(name, resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        wait_handshake(0, {name, " write address"});
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_handshake(1, {name, " write response"});
    endtask

    task automatic axil_read(input string name, input logic [3:0] addr,
                             input logic [1:0] resp, input logic [31:0] data);
        i_check.expect_read(name, resp, data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        wait_handshake(2, {name, " read address"});
        @(negedge clk);
        arvalid = 1'b0;
        wait_handshake(3, {name, " read response"});
    endtask

    task automatic run_trace();
        int          fd;
        int          code;
        int          ch;
        string       name;
        string       op;
        logic [31:0] off;
        logic [31:0] data;
        logic [31:0] resp;
        logic [31:0] exp_data;
        fd = $fopen("tests/mbox_trace.txt", "r");
        if (fd == 0) begin
            i_check.note_failure("Could not open the trace file tests/mbox_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1)
                break;
            if (name.getc(0) == "#") begin
                ch = $fgetc(fd);                  // Skip the rest of a comment line
                while (ch != "\n" && ch != -1)
                    ch = $fgetc(fd);
            end else begin
                code = $fscanf(fd, "%s %h %h %h %h", op, off, data, resp, exp_data);
                if (code != 5) begin
                    i_check.note_failure({"The trace line for ", name, " is incomplete"});
                    break;
                end
                if (op == "write")
                    axil_write(name, off[3:0], data, resp[1:0]);
                else
                    axil_read(name, off[3:0], resp[1:0], exp_data);
            end
        end
        $fclose(fd);
    endtask

    // Pushes, pops and register reads against the queue model, under stalls
    task automatic run_random();
        logic [31:0] word;
        logic        do_push;
        string       name;
        stall_en = 1'b1;
        for (int i = 0; i < random_ops; i++) begin
            rand_state = xorshift32(rand_state);
            name = $sformatf("random_%0d", i);
            if (rand_state[1:0] == 2'd3) begin
                if (rand_state[2])
                    axil_read(name, mbox_pkg::reg_count, mbox_pkg::resp_okay, model.size());
                else
                    axil_read(name, mbox_pkg::reg_status, mbox_pkg::resp_okay,
                              status_for(model.size(), 1'b0, 1'b0));
            end else begin
                do_push = !rand_state[0];
                if (model.size() == 0)
                    do_push = 1'b1;
                if (model.size() == mbox_pkg::fifo_depth)
                    do_push = 1'b0;
                if (do_push) begin
                    rand_state = xorshift32(rand_state);
                    word = rand_state;
                    model.push_back(word);
                    axil_write(name, mbox_pkg::reg_data, word, mbox_pkg::resp_okay);
                end else begin
                    word = model.pop_front();
                    axil_read(name, mbox_pkg::reg_data, mbox_pkg::resp_okay, word);
                end
            end
        end
        stall_en = 1'b0;
    endtask

    // Random back-pressure on B and R
    initial begin
        forever begin
            @(negedge clk);
            if (stall_en) begin
                stall_state = xorshift32(stall_state);
                bready = stall_state[0] | stall_state[1];
                rready = stall_state[2] | stall_state[3];
            end else begin
                bready = 1'b1;
                rready = 1'b1;
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        stall_en    = 1'b0;
        rand_state  = seed;
        stall_state = xorshift32(~seed);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        run_trace();
        run_random();
        repeat (4) @(posedge clk);

        i_check.check_drained();
        i_check.report_counts();
        if (i_check.fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: tests/mbox_trace.txt
# name op offset wdata resp rdata, numbers in hex
# resp 0 is okay and 2 is slverr, rdata is checked on reads only
status_reset read 4 0 0 5
push_0 write 0 a5a50001 0 0
push_1 write 0 a5a50002 0 0
push_2 write 0 a5a50003 0 0
push_3 write 0 a5a50004 0 0
push_4 write 0 a5a50005 0 0
push_5 write 0 a5a50006 0 0
push_6 write 0 a5a50007 0 0
push_7 write 0 a5a50008 0 0
count_full read 8 0 0 8
status_full read 4 0 0 a
push_over write 0 deadbeef 0 0
status_ovf read 4 0 0 1a
count_over read 8 0 0 8
clear_ovf write 4 10 0 0
status_ovf_clr read 4 0 0 a
pop_0 read 0 0 0 a5a50001
status_afull read 4 0 0 8
pop_1 read 0 0 0 a5a50002
pop_2 read 0 0 0 a5a50003
pop_3 read 0 0 0 a5a50004
pop_4 read 0 0 0 a5a50005
pop_5 read 0 0 0 a5a50006
pop_6 read 0 0 0 a5a50007
status_aempty read 4 0 0 4
pop_7 read 0 0 0 a5a50008
status_empty read 4 0 0 5
pop_under read 0 0 0 0
status_unf read 4 0 0 25
clear_unf write 4 20 0 0
status_unf_clr read 4 0 0 5
wr_count write 8 1234 2 0
rd_unmapped read c 0 2 0
wr_unmapped write c 5555 2 0
count_after read 8 0 0 0

// File: build.f
source/mbox_pkg.sv
source/sync_fifo.sv
source/mbox_axil_regs.sv
source/mbox_top.sv
tests/mbox_checker.sv
tests/tb_mbox.sv

// File: Bender.yml
package:
  name: mbox

sources:
  - source/mbox_pkg.sv
  - source/sync_fifo.sv
  - source/mbox_axil_regs.sv
  - source/mbox_top.sv
  - target: test
    files:
      - tests/mbox_checker.sv
      - tests/tb_mbox.sv
